//--- design/mbx_config.svh
`ifndef MBX_CONFIG_SVH
`define MBX_CONFIG_SVH

// ====================
// Mailbox port geometry
// ====================

// Word address into the mailbox RAM
`define MBX_ADDR_W 9

// Data word width
`define MBX_DATA_W 32

// ECC status bits returned with each read
`define MBX_ECC_W 2

// Cycles from read strobe to data capture, must be 2 or more
`define MBX_RD_LATENCY 4

`endif

//--- design/mbx_bus_pkg.sv
`include "mbx_config.svh"

package mbx_bus_pkg;

   // Mailbox word address
   typedef logic [`MBX_ADDR_W-1:0] mbx_addr_t;

   // Mailbox data word
   typedef logic [`MBX_DATA_W-1:0] mbx_data_t;

   // ECC status from the mailbox
   typedef logic [`MBX_ECC_W-1:0] mbx_ecc_t;

   // One command toward the mailbox port
   // Write and read flags never set together
   typedef struct packed {
      logic      wr;
      logic      rd;
      mbx_addr_t addr;
      // Only meaningful for writes
      mbx_data_t wdata;
   } mbx_cmd_t;

endpackage

//--- design/mbx_ctrl_pkg.sv
package mbx_ctrl_pkg;

   // Session controller states
   typedef enum logic [3:0] {
      IDLE         = 4'd0,
      // Write session
      WR_LOAD      = 4'd1,
      WR_ACTIVE    = 4'd2,
      WR_DONE      = 4'd3,
      // Read session
      RD_LOAD      = 4'd4,
      RD_ISSUE     = 4'd5,
      RD_WAIT      = 4'd6,
      RD_DATA      = 4'd7,
      RD_DONE_WAIT = 4'd8,
      RD_DONE      = 4'd9
   } session_state_t;

endpackage

//--- design/mbx_cmd_if.sv
`timescale 1ns/1ps

interface mbx_cmd_if;
   import mbx_bus_pkg::*;

   // One-cycle command strobe
   logic     cmd_valid;

   // Command payload, valid with cmd_valid
   mbx_cmd_t cmd;

   // Read data captured, one-cycle pulse
   logic     rd_data_ready;

   // Session controller side
   modport ctrl (
      output cmd_valid,
      output cmd,
      input  rd_data_ready
   );

   // Port register side
   modport drv (
      input cmd_valid,
      input cmd
   );

   // Read capture side
   modport cap (
      input  cmd_valid,
      input  cmd,
      output rd_data_ready
   );

endinterface

//--- design/mbx_session_ctrl.sv
`timescale 1ns/1ps

module mbx_session_ctrl (
   input  logic                   CLK,
   input  logic                   RESETN,
   // Backend session control
   input  logic                   wr_init,
   input  logic                   rd_init,
   input  logic                   wrreq_done,
   input  logic                   rdreq_done,
   input  logic                   wdata_nxtreq,
   input  logic                   rdata_nxtreq,
   // Backend address and data
   input  mbx_bus_pkg::mbx_addr_t wr_addr,
   input  mbx_bus_pkg::mbx_addr_t rd_addr,
   input  mbx_bus_pkg::mbx_data_t wdata,
   // Backend handshake outputs
   output logic                   wdata_clrreq,
   output logic                   rdata_clrreq,
   output logic                   wr_done,
   output logic                   rd_done,
   // Commands toward the port side
   mbx_cmd_if.ctrl                cmd
);
   import mbx_bus_pkg::*;
   import mbx_ctrl_pkg::*;

   session_state_t state;
   session_state_t state_next;

   // Delayed copies for edge detection
   logic wr_init_q;
   logic rd_init_q;
   logic rdata_nxtreq_q;

   logic wr_init_rise;
   logic rd_init_rise;
   logic nxtreq_fall;

   // Next values of the registered clear-requests
   logic wdata_clrreq_next;
   logic rdata_clrreq_next;

   // Command built this cycle
   logic     issue_valid;
   mbx_cmd_t issue_cmd;

   // ====================
   // Edge detection
   // ====================
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         wr_init_q      <= 1'b0;
         rd_init_q      <= 1'b0;
         rdata_nxtreq_q <= 1'b0;
      end
      else begin
         wr_init_q      <= wr_init;
         rd_init_q      <= rd_init;
         rdata_nxtreq_q <= rdata_nxtreq;
      end
   end

   // Sessions start on the rising edge only
   assign wr_init_rise = wr_init & ~wr_init_q;
   assign rd_init_rise = rd_init & ~rd_init_q;

   // Backend read acknowledge completes on the falling edge
   assign nxtreq_fall  = ~rdata_nxtreq & rdata_nxtreq_q;

   // ====================
   // Session FSM
   // ====================
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         state        <= IDLE;
         wdata_clrreq <= 1'b0;
         rdata_clrreq <= 1'b0;
      end
      else begin
         state        <= state_next;
         wdata_clrreq <= wdata_clrreq_next;
         rdata_clrreq <= rdata_clrreq_next;
      end
   end

   always_comb begin
      state_next        = state;
      issue_valid       = 1'b0;
      issue_cmd         = '0;
      wdata_clrreq_next = 1'b0;
      rdata_clrreq_next = 1'b0;

      case (state)
         IDLE: begin
            // Write init wins over read init
            if (wr_init_rise) begin
               state_next = WR_LOAD;
            end
            else if (rd_init_rise) begin
               state_next = RD_LOAD;
            end
         end

         WR_LOAD: begin
            state_next = WR_ACTIVE;
         end

         WR_ACTIVE: begin
            // Session close beats a pending data request
            if (wrreq_done) begin
               state_next = WR_DONE;
            end
            else if (wdata_nxtreq && !wdata_clrreq) begin
               issue_valid       = 1'b1;
               issue_cmd.wr      = 1'b1;
               issue_cmd.addr    = wr_addr;
               issue_cmd.wdata   = wdata;
               wdata_clrreq_next = 1'b1;
            end
         end

         WR_DONE: begin
            state_next = IDLE;
         end

         RD_LOAD: begin
            state_next = RD_ISSUE;
         end

         RD_ISSUE: begin
            issue_valid    = 1'b1;
            issue_cmd.rd   = 1'b1;
            issue_cmd.addr = rd_addr;
            state_next     = RD_WAIT;
         end

         RD_WAIT: begin
            // Hand over once the capture register loads
            if (cmd.rd_data_ready) begin
               rdata_clrreq_next = 1'b1;
               state_next        = RD_DATA;
            end
         end

         RD_DATA: begin
            // Hold clear-request until backend acknowledges
            rdata_clrreq_next = 1'b1;
            if (nxtreq_fall) begin
               rdata_clrreq_next = 1'b0;
               state_next        = rdreq_done ? RD_DONE_WAIT : RD_ISSUE;
            end
         end

         RD_DONE_WAIT: begin
            state_next = RD_DONE;
         end

         RD_DONE: begin
            state_next = IDLE;
         end

         default: begin
            state_next = IDLE;
         end
      endcase
   end

   assign cmd.cmd_valid = issue_valid;
   assign cmd.cmd       = issue_cmd;

   // One-cycle done pulses in the last state before IDLE
   assign wr_done = (state == WR_DONE);
   assign rd_done = (state == RD_DONE);

endmodule

//--- design/mbx_port_driver.sv
`timescale 1ns/1ps

module mbx_port_driver (
   input  logic                   CLK,
   input  logic                   RESETN,
   // Commands from the controller
   mbx_cmd_if.drv                 cmd,
   // Mailbox port
   output logic                   mbx_write,
   output logic                   mbx_read,
   output mbx_bus_pkg::mbx_addr_t mbx_addr,
   output mbx_bus_pkg::mbx_data_t mbx_wdata
);

   logic wr_issue;
   logic rd_issue;

   // Decode the strobe for this cycle
   assign wr_issue = cmd.cmd_valid & cmd.cmd.wr;
   assign rd_issue = cmd.cmd_valid & cmd.cmd.rd;

   // ====================
   // Port registers
   // ====================
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         mbx_write <= 1'b0;
         mbx_read  <= 1'b0;
         mbx_addr  <= '0;
         mbx_wdata <= '0;
      end
      else begin
         // Strobes last exactly one cycle
         mbx_write <= wr_issue;
         mbx_read  <= rd_issue;

         // Address stays put between commands
         if (cmd.cmd_valid) begin
            mbx_addr <= cmd.cmd.addr;
         end

         // Data bus idles at zero
         if (wr_issue) begin
            mbx_wdata <= cmd.cmd.wdata;
         end
         else begin
            mbx_wdata <= '0;
         end
      end
   end

endmodule

//--- design/mbx_read_capture.sv
`timescale 1ns/1ps
`include "mbx_config.svh"

module mbx_read_capture (
   input  logic                   CLK,
   input  logic                   RESETN,
   // Commands from the controller
   mbx_cmd_if.cap                 cmd,
   // Mailbox read return
   input  mbx_bus_pkg::mbx_data_t mbx_rdata,
   input  mbx_bus_pkg::mbx_ecc_t  mbx_ecc,
   // Captured word toward the backend
   output mbx_bus_pkg::mbx_data_t bk_rdata,
   output mbx_bus_pkg::mbx_ecc_t  bk_ecc
);

   // Wide enough to hold the full latency
   localparam int CNT_W = $clog2(`MBX_RD_LATENCY + 1);

   logic [CNT_W-1:0] lat_cnt;
   logic             rd_issue;
   logic             capture;

   assign rd_issue = cmd.cmd_valid & cmd.cmd.rd;

   // ====================
   // Latency counter
   // ====================
   // Loaded with the command, reaches 1 in the data cycle
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         lat_cnt <= '0;
      end
      else if (rd_issue) begin
         lat_cnt <= CNT_W'(`MBX_RD_LATENCY);
      end
      else if (lat_cnt != '0) begin
         lat_cnt <= lat_cnt - 1'b1;
      end
   end

   // Mailbox data is valid while the count sits at 1
   assign capture = (lat_cnt == CNT_W'(1));

   // ====================
   // Capture register
   // ====================
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         bk_rdata <= '0;
         bk_ecc   <= '0;
      end
      else if (capture) begin
         bk_rdata <= mbx_rdata;
         bk_ecc   <= mbx_ecc;
      end
   end

   // Tell the controller in the same cycle as the load
   assign cmd.rd_data_ready = capture;

endmodule

//--- design/mbx_bridge_top.sv
`timescale 1ns/1ps

module mbx_bridge_top (
   input  logic                   CLK,
   input  logic                   RESETN,
   // Backend session control
   input  logic                   wr_init,
   input  logic                   rd_init,
   input  logic                   wrreq_done,
   input  logic                   rdreq_done,
   input  logic                   wdata_nxtreq,
   input  logic                   rdata_nxtreq,
   input  mbx_bus_pkg::mbx_addr_t wr_addr,
   input  mbx_bus_pkg::mbx_addr_t rd_addr,
   input  mbx_bus_pkg::mbx_data_t wdata,
   // Backend handshake and read return
   output logic                   wdata_clrreq,
   output logic                   rdata_clrreq,
   output logic                   wr_done,
   output logic                   rd_done,
   output mbx_bus_pkg::mbx_data_t bk_rdata,
   output mbx_bus_pkg::mbx_ecc_t  bk_ecc,
   // Mailbox port
   output logic                   mbx_write,
   output logic                   mbx_read,
   output mbx_bus_pkg::mbx_addr_t mbx_addr,
   output mbx_bus_pkg::mbx_data_t mbx_wdata,
   input  mbx_bus_pkg::mbx_data_t mbx_rdata,
   input  mbx_bus_pkg::mbx_ecc_t  mbx_ecc
);

   // Internal command path
   mbx_cmd_if u_cmd_if ();

   // ====================
   // Session control
   // ====================
   mbx_session_ctrl u_session_ctrl (
      .CLK          (CLK),
      .RESETN       (RESETN),
      .wr_init      (wr_init),
      .rd_init      (rd_init),
      .wrreq_done   (wrreq_done),
      .rdreq_done   (rdreq_done),
      .wdata_nxtreq (wdata_nxtreq),
      .rdata_nxtreq (rdata_nxtreq),
      .wr_addr      (wr_addr),
      .rd_addr      (rd_addr),
      .wdata        (wdata),
      .wdata_clrreq (wdata_clrreq),
      .rdata_clrreq (rdata_clrreq),
      .wr_done      (wr_done),
      .rd_done      (rd_done),
      .cmd          (u_cmd_if.ctrl)
   );

   // Mailbox port registers
   mbx_port_driver u_port_driver (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .cmd       (u_cmd_if.drv),
      .mbx_write (mbx_write),
      .mbx_read  (mbx_read),
      .mbx_addr  (mbx_addr),
      .mbx_wdata (mbx_wdata)
   );

   // Read latency and data capture
   mbx_read_capture u_read_capture (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .cmd       (u_cmd_if.cap),
      .mbx_rdata (mbx_rdata),
      .mbx_ecc   (mbx_ecc),
      .bk_rdata  (bk_rdata),
      .bk_ecc    (bk_ecc)
   );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic CLK
);

   // 8 ns period
   localparam real HALF_PERIOD = 4.0;

   initial begin
      CLK = 1'b0;
   end

   always #(HALF_PERIOD) CLK = ~CLK;

endmodule

//--- dv/mbx_mem_model.sv
`timescale 1ns/1ps
`include "mbx_config.svh"

module mbx_mem_model (
   input  logic                   CLK,
   input  logic                   mbx_write,
   input  logic                   mbx_read,
   input  mbx_bus_pkg::mbx_addr_t mbx_addr,
   input  mbx_bus_pkg::mbx_data_t mbx_wdata,
   output mbx_bus_pkg::mbx_data_t mbx_rdata,
   output mbx_bus_pkg::mbx_ecc_t  mbx_ecc
);
   import mbx_bus_pkg::*;

   // Data valid LATENCY-1 cycles after the read strobe cycle
   localparam int STAGES    = `MBX_RD_LATENCY - 1;
   localparam int LOG_DEPTH = 64;

   mbx_data_t mem [0:(1 << `MBX_ADDR_W) - 1];
   mbx_data_t pipe [STAGES];

   // Write log, read by the testbench
   mbx_addr_t log_addr [LOG_DEPTH];
   mbx_data_t log_data [LOG_DEPTH];
   int        wr_count = 0;
   int        rd_count = 0;

   // Fill word mixes every address bit
   initial begin
      for (int i = 0; i < (1 << `MBX_ADDR_W); i++) begin
         mem[i] = 32'h6d2b79f5 * (i + 1);
      end
   end

   always @(posedge CLK) begin
      if (mbx_write) begin
         mem[mbx_addr] <= mbx_wdata;
         if (wr_count < LOG_DEPTH) begin
            log_addr[wr_count] <= mbx_addr;
            log_data[wr_count] <= mbx_wdata;
         end
         wr_count <= wr_count + 1;
      end
      if (mbx_read) begin
         rd_count <= rd_count + 1;
      end
      // Read pipeline
      pipe[0] <= mbx_read ? mem[mbx_addr] : '0;
      for (int i = 1; i < STAGES; i++) begin
         pipe[i] <= pipe[i-1];
      end
   end

   assign mbx_rdata = pipe[STAGES-1];

   // ECC status: low two bits XOR top two bits
   assign mbx_ecc = mbx_rdata[1:0] ^ mbx_rdata[`MBX_DATA_W-1 -: 2];

endmodule

//--- dv/mbx_bridge_properties.sv
`timescale 1ns/1ps

module mbx_bridge_properties (
   input logic                         CLK,
   input logic                         RESETN,
   input logic                         mbx_write,
   input logic                         mbx_read,
   input logic                         wr_done,
   input logic                         rd_done,
   input logic                         wdata_clrreq,
   input mbx_ctrl_pkg::session_state_t state
);
   import mbx_ctrl_pkg::*;

   // Failures seen so far
   int fail_count = 0;

   // ====================
   // Port strobes
   // ====================
   write_read_exclusive: assert property (@(posedge CLK) disable iff (!RESETN)
      !(mbx_write && mbx_read))
      else begin
         $error("mbx_write and mbx_read were high together");
         fail_count++;
      end

   // Every write strobe comes with its clear-request
   write_has_clrreq: assert property (@(posedge CLK) disable iff (!RESETN)
      mbx_write |-> wdata_clrreq)
      else begin
         $error("mbx_write without wdata_clrreq");
         fail_count++;
      end

   // Read strobe follows the issue state
   read_after_issue: assert property (@(posedge CLK) disable iff (!RESETN)
      mbx_read |-> $past(state) == RD_ISSUE)
      else begin
         $error("mbx_read not preceded by RD_ISSUE");
         fail_count++;
      end

   // ====================
   // Done pulses
   // ====================
   wr_done_single: assert property (@(posedge CLK) disable iff (!RESETN)
      wr_done |=> !wr_done)
      else begin
         $error("wr_done lasted more than one cycle");
         fail_count++;
      end

   rd_done_single: assert property (@(posedge CLK) disable iff (!RESETN)
      rd_done |=> !rd_done)
      else begin
         $error("rd_done lasted more than one cycle");
         fail_count++;
      end

endmodule

bind mbx_bridge_top mbx_bridge_properties u_props (
   .CLK          (CLK),
   .RESETN       (RESETN),
   .mbx_write    (mbx_write),
   .mbx_read     (mbx_read),
   .wr_done      (wr_done),
   .rd_done      (rd_done),
   .wdata_clrreq (wdata_clrreq),
   .state        (u_session_ctrl.state)
);

//--- dv/mbx_bridge_tb.sv
`timescale 1ns/1ps

module mbx_bridge_tb;
   import mbx_bus_pkg::*;

   // Cycle bound per word and words over all tests
   localparam int WORD_CYCLES = 40;
   localparam int TOTAL_WORDS = 1 + 8 + 6 + 8 + 1 + 4;
   localparam int TIMEOUT_NS  = (TOTAL_WORDS * WORD_CYCLES + 48) * 8;

   // Selectors for the wait helper
   localparam int SIG_WCLR  = 0;
   localparam int SIG_RCLR  = 1;
   localparam int SIG_WDONE = 2;
   localparam int SIG_RDONE = 3;

   logic      CLK;
   logic      RESETN;
   logic      wr_init;
   logic      rd_init;
   logic      wrreq_done;
   logic      rdreq_done;
   logic      wdata_nxtreq;
   logic      rdata_nxtreq;
   mbx_addr_t wr_addr;
   mbx_addr_t rd_addr;
   mbx_data_t wdata;
   logic      wdata_clrreq;
   logic      rdata_clrreq;
   logic      wr_done;
   logic      rd_done;
   mbx_data_t bk_rdata;
   mbx_ecc_t  bk_ecc;
   logic      mbx_write;
   logic      mbx_read;
   mbx_addr_t mbx_addr;
   mbx_data_t mbx_wdata;
   mbx_data_t mbx_rdata;
   mbx_ecc_t  mbx_ecc;

   int          errors = 0;
   int          wr_done_cnt = 0;
   int          rd_done_cnt = 0;
   string       test_name = "init";
   logic [31:0] rng = 32'hea805842;

   // Word lists shared by the session tasks
   mbx_addr_t addr_list [8];
   mbx_data_t data_list [8];

   tb_clk_gen u_clk_gen (.CLK(CLK));

   mbx_bridge_top u_mbx_bridge_top (.*);

   mbx_mem_model u_mem (.*);

   // Done pulse counters
   always @(posedge CLK) begin
      if (wr_done) wr_done_cnt++;
      if (rd_done) rd_done_cnt++;
   end

   // ====================
   // Helpers
   // ====================
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // ECC rule of the mailbox
   function automatic mbx_ecc_t ecc_of(input mbx_data_t d);
      return d[1:0] ^ d[31:30];
   endfunction

   function automatic logic probe(input int sel);
      case (sel)
         SIG_WCLR:  return wdata_clrreq;
         SIG_RCLR:  return rdata_clrreq;
         SIG_WDONE: return wr_done;
         default:   return rd_done;
      endcase
   endfunction

   // Lands 1 ns after the rising edge
   task automatic tick();
      @(posedge CLK);
      #1;
   endtask

   task automatic check_eq(input string what, input logic [63:0] expv,
                           input logic [63:0] actv);
      assert (actv === expv)
      else begin
         $display("** Error %s: %s expected %0h actual %0h", test_name, what, expv, actv);
         errors++;
      end
   endtask

   task automatic wait_until(input string what, input int sel);
      int n;
      n = 0;
      do begin
         tick();
         n++;
      end while (!probe(sel) && n < WORD_CYCLES);
      assert (probe(sel))
      else begin
         $display("%s: %s never went high", test_name, what);
         errors++;
      end
   endtask

   // Distinct addresses, random data
   task automatic make_words(input int n);
      mbx_addr_t base;
      base = mbx_addr_t'(next_rand());
      for (int i = 0; i < n; i++) begin
         addr_list[i] = base + mbx_addr_t'(i * 37);
         data_list[i] = next_rand();
      end
   endtask

   task automatic check_idle_outputs();
      check_eq("strobes, handshakes, addr", '0, {mbx_write, mbx_read, wdata_clrreq,
               rdata_clrreq, wr_done, rd_done, bk_ecc, mbx_addr});
      check_eq("mbx_wdata", '0, mbx_wdata);
      check_eq("bk_rdata", '0, bk_rdata);
   endtask

   // ====================
   // Session tasks
   // ====================
   task automatic write_session(input int n);
      int wr_base;
      int done_base;
      wr_base   = u_mem.wr_count;
      done_base = wr_done_cnt;
      wr_init   = 1'b1;
      tick();
      wr_init = 1'b0;
      for (int i = 0; i < n; i++) begin
         wr_addr      = addr_list[i];
         wdata        = data_list[i];
         wdata_nxtreq = 1'b1;
         wait_until("wdata_clrreq", SIG_WCLR);
         check_eq("mbx_write", 1, mbx_write);
         check_eq("mbx_addr", addr_list[i], mbx_addr);
         check_eq("mbx_wdata", data_list[i], mbx_wdata);
         // Lower the request on the clear cycle
         wdata_nxtreq = 1'b0;
         tick();
         check_eq("wdata_clrreq one cycle", 0, wdata_clrreq);
      end
      wrreq_done = 1'b1;
      wait_until("wr_done", SIG_WDONE);
      wrreq_done = 1'b0;
      tick();
      check_eq("wr_done pulses", 1, wr_done_cnt - done_base);
      check_eq("mbx_write count", n, u_mem.wr_count - wr_base);
      for (int i = 0; i < n; i++) begin
         check_eq("logged addr", addr_list[i], u_mem.log_addr[wr_base + i]);
         check_eq("logged data", data_list[i], u_mem.log_data[wr_base + i]);
      end
   endtask

   // Expected words come from data_list
   task automatic read_session(input int n, input logic keep_init);
      int rd_base;
      int done_base;
      rd_base   = u_mem.rd_count;
      done_base = rd_done_cnt;
      rd_addr   = addr_list[0];
      rd_init   = 1'b1;
      for (int i = 0; i < n; i++) begin
         wait_until("rdata_clrreq", SIG_RCLR);
         if (!keep_init) rd_init = 1'b0;
         check_eq("bk_rdata", data_list[i], bk_rdata);
         check_eq("bk_ecc", ecc_of(data_list[i]), bk_ecc);
         // High-then-low acknowledge
         rdata_nxtreq = 1'b1;
         tick();
         check_eq("rdata_clrreq held", 1, rdata_clrreq);
         rdata_nxtreq = 1'b0;
         rdreq_done   = (i == n - 1);
         if (i < n - 1) rd_addr = addr_list[i + 1];
      end
      wait_until("rd_done", SIG_RDONE);
      rdreq_done = 1'b0;
      tick();
      check_eq("rd_done pulses", 1, rd_done_cnt - done_base);
      check_eq("mbx_read count", n, u_mem.rd_count - rd_base);
   endtask

   // ====================
   // Tests
   // ====================
   task automatic test_reset();
      test_name = "reset";
      repeat (4) @(posedge CLK);
      #1;
      check_idle_outputs();
      repeat (4) @(posedge CLK);
      #1;
      RESETN = 1'b1;
      tick();
      tick();
      check_idle_outputs();
   endtask

   task automatic test_write_burst();
      test_name = "write_burst";
      make_words(8);
      write_session(8);
   endtask

   task automatic test_read_burst();
      test_name = "read_burst";
      make_words(6);
      for (int i = 0; i < 6; i++) begin
         u_mem.mem[addr_list[i]] = data_list[i];
      end
      read_session(6, 1'b0);
   endtask

   task automatic test_write_read_back();
      test_name = "write_read_back";
      make_words(4);
      write_session(4);
      read_session(4, 1'b0);
   endtask

   task automatic test_empty_write();
      test_name = "empty_write";
      write_session(0);
   endtask

   // rd_init held high over the whole session
   task automatic test_init_level_held();
      int rd_base;
      int done_base;
      test_name = "init_level_held";
      make_words(4);
      for (int i = 0; i < 4; i++) begin
         u_mem.mem[addr_list[i]] = data_list[i];
      end
      rd_base   = u_mem.rd_count;
      done_base = rd_done_cnt;
      read_session(4, 1'b1);
      repeat (20) tick();
      check_eq("reads in held session", 4, u_mem.rd_count - rd_base);
      check_eq("rd_done in held session", 1, rd_done_cnt - done_base);
      rd_init = 1'b0;
      tick();
   endtask

   // Watchdog
   initial begin
      #(TIMEOUT_NS * 1ns);
      $display("Watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
      $display("Errors found");
      $finish;
   end

   initial begin
      RESETN       = 1'b0;
      wr_init      = 1'b0;
      rd_init      = 1'b0;
      wrreq_done   = 1'b0;
      rdreq_done   = 1'b0;
      wdata_nxtreq = 1'b0;
      rdata_nxtreq = 1'b0;
      wr_addr      = '0;
      rd_addr      = '0;
      wdata        = '0;
      test_reset();
      test_write_burst();
      test_read_burst();
      test_write_read_back();
      test_empty_write();
      test_init_level_held();
      $display("Summary: %0d check errors, %0d assertion failures", errors,
               u_mbx_bridge_top.u_props.fail_count);
      if (errors + u_mbx_bridge_top.u_props.fail_count == 0) begin
         $display("No errors");
      end
      else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+design
design/mbx_bus_pkg.sv
design/mbx_ctrl_pkg.sv
design/mbx_cmd_if.sv
design/mbx_session_ctrl.sv
design/mbx_port_driver.sv
design/mbx_read_capture.sv
design/mbx_bridge_top.sv
dv/tb_clk_gen.sv
dv/mbx_mem_model.sv
dv/mbx_bridge_properties.sv
dv/mbx_bridge_tb.sv
